// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [1:0]  access_size_t;

    // Access size codes
    localparam access_size_t SIZE_WORD = 2'b00;
    localparam access_size_t SIZE_HALF = 2'b01;
    localparam access_size_t SIZE_BYTE = 2'b10;
    localparam access_size_t SIZE_NONE = 2'b11;

    // RV32I major opcodes for memory instructions
    localparam opcode_t OP_LOAD  = 7'b0000011;
    localparam opcode_t OP_STORE = 7'b0100011;

    // Width part of funct3, shared by loads and stores
    localparam funct3_t F3_BYTE = 3'b000;
    localparam funct3_t F3_HALF = 3'b001;
    localparam funct3_t F3_WORD = 3'b010;

    // Set for LBU and LHU
    localparam int F3_UNSIGNED_BIT = 2;

endpackage

`default_nettype wire

// File: design/mem_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if
    import mem_pkg::*;
#(
    parameter int unsigned DEPTH_WORDS = 256
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    logic             en;
    logic             we;
    logic [IDX_W-1:0] index;
    word_t            wdata;
    byte_en_t         be;
    word_t            rdata;

    modport master (
        output en, we, index, wdata, be,
        input  rdata
    );

    modport slave (
        input  en, we, index, wdata, be,
        output rdata
    );

endinterface

`default_nettype wire

// File: design/mem_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl
    import mem_pkg::*;
(
    input  opcode_t      opcode,
    input  funct3_t      funct3,
    output access_size_t access_size,
    output logic         mem_write,
    output logic         mem_access
);

    logic is_load;
    logic is_store;

    always_comb begin
        is_load  = (opcode == OP_LOAD);
        is_store = (opcode == OP_STORE);
    end

    // Access size from funct3
    always_comb begin
        access_size = SIZE_NONE;
        if (is_load) begin
            // Bit 2 only picks sign or zero extension
            case (funct3[1:0])
                F3_BYTE[1:0]: access_size = SIZE_BYTE;
                F3_HALF[1:0]: access_size = SIZE_HALF;
                F3_WORD[1:0]: access_size = SIZE_WORD;
                default:      access_size = SIZE_NONE;
            endcase
        end else if (is_store) begin
            // Stores have no unsigned forms, so all three bits count
            case (funct3)
                F3_BYTE: access_size = SIZE_BYTE;
                F3_HALF: access_size = SIZE_HALF;
                F3_WORD: access_size = SIZE_WORD;
                default: access_size = SIZE_NONE;
            endcase
        end
    end

    // Only stores write
    always_comb begin
        mem_write = 1'b0;
        if (is_store) begin
            mem_write = 1'b1;
        end
    end

    always_comb begin
        mem_access = 1'b0;
        if (is_load || is_store) begin
            mem_access = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/lsu_align.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_align
    import mem_pkg::*;
#(
    parameter int unsigned DEPTH_WORDS = 256
)(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid,
    input  funct3_t          funct3,
    input  addr_t            addr,
    input  word_t            store_data,
    input  access_size_t     access_size,
    input  logic             mem_write,
    input  logic             mem_access,
    mem_bus_if.master        bus,
    output logic             load_valid,
    output word_t            load_data,
    output logic             fault
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    logic         misaligned;
    logic         legal;
    logic         fault_next;
    byte_en_t     be_next;
    word_t        wdata_next;

    // State carried into the extension cycle
    logic [1:0]   lane_q;
    access_size_t size_q;
    logic         unsigned_q;
    logic         load_q;
    logic         fault_q;

    // Natural alignment where SIZE_NONE is never legal
    always_comb begin
        case (access_size)
            SIZE_WORD: misaligned = (addr[1:0] != 2'b00);
            SIZE_HALF: misaligned = addr[0];
            SIZE_BYTE: misaligned = 1'b0;
            default:   misaligned = 1'b1;
        endcase
    end

    assign legal      = req_valid && mem_access && !misaligned;
    assign fault_next = req_valid && mem_access && misaligned;

    // Byte enables and lane replication of store data
    always_comb begin
        case (access_size)
            SIZE_BYTE: begin
                be_next    = 4'b0001 << addr[1:0];
                wdata_next = {4{store_data[7:0]}};
            end
            SIZE_HALF: begin
                be_next    = addr[1] ? 4'b1100 : 4'b0011;
                wdata_next = {2{store_data[15:0]}};
            end
            default: begin
                be_next    = 4'b1111;
                wdata_next = store_data;
            end
        endcase
    end

    // Address bits above the RAM size are dropped, so accesses wrap
    assign bus.en    = legal;
    assign bus.we    = mem_write;
    assign bus.index = addr[IDX_W+1:2];
    assign bus.wdata = wdata_next;
    assign bus.be    = be_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            load_q  <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            load_q  <= legal && !mem_write;
            fault_q <= fault_next;
        end
    end

    always_ff @(posedge clk) begin
        lane_q     <= addr[1:0];
        size_q     <= access_size;
        unsigned_q <= funct3[F3_UNSIGNED_BIT];
    end

    // Lane select and extension on the returned word
    always_comb begin
        logic [7:0]  byte_val;
        logic [15:0] half_val;

        byte_val = bus.rdata[lane_q*8 +: 8];
        half_val = lane_q[1] ? bus.rdata[31:16] : bus.rdata[15:0];
        case (size_q)
            SIZE_BYTE: begin
                if (unsigned_q) begin
                    load_data = {24'b0, byte_val};
                end else begin
                    load_data = {{24{byte_val[7]}}, byte_val};
                end
            end
            SIZE_HALF: begin
                if (unsigned_q) begin
                    load_data = {16'b0, half_val};
                end else begin
                    load_data = {{16{half_val[15]}}, half_val};
                end
            end
            default: load_data = bus.rdata;
        endcase
    end

    assign load_valid = load_q;
    assign fault      = fault_q;

endmodule

`default_nettype wire

// File: design/data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module data_ram
    import mem_pkg::*;
#(
    parameter int unsigned DEPTH_WORDS = 256
)(
    input  logic     clk,
    mem_bus_if.slave bus
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);

    word_t            mem_q [DEPTH_WORDS];
    logic [IDX_W-1:0] idx;

    assign idx = bus.index;

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (bus.en && bus.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.be[i]) begin
                    mem_q[idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Registered read that returns old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (bus.en && !bus.we) begin
            bus.rdata <= mem_q[idx];
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage
    import mem_pkg::*;
#(
    parameter int unsigned DEPTH_WORDS = 256
)(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    req_valid,
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  addr_t   addr,
    input  word_t   store_data,
    output logic    load_valid,
    output word_t   load_data,
    output logic    fault
);

    access_size_t access_size;
    logic         mem_write;
    logic         mem_access;

    mem_bus_if #(.DEPTH_WORDS(DEPTH_WORDS)) ram_bus ();

    // Opcode and funct3 decode
    mem_ctrl i_mem_ctrl (
        .opcode      (opcode),
        .funct3      (funct3),
        .access_size (access_size),
        .mem_write   (mem_write),
        .mem_access  (mem_access)
    );

    lsu_align #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_lsu_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .funct3      (funct3),
        .addr        (addr),
        .store_data  (store_data),
        .access_size (access_size),
        .mem_write   (mem_write),
        .mem_access  (mem_access),
        .bus         (ram_bus.master),
        .load_valid  (load_valid),
        .load_data   (load_data),
        .fault       (fault)
    );

    data_ram #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_data_ram (
        .clk (clk),
        .bus (ram_bus.slave)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for 5 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/mem_stage_checker.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_checker (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic req_valid,
    input wire logic load_valid,
    input wire logic fault
);

    // A request ends either as load data or as a fault, never both
    property no_load_and_fault;
        @(posedge clk) disable iff (!rst_n)
            !(load_valid && fault);
    endproperty

    // Outputs only answer an accepted request
    property quiet_after_idle;
        @(posedge clk) disable iff (!rst_n)
            !req_valid |=> (!load_valid && !fault);
    endproperty

    load_fault_excl_a: assert property (no_load_and_fault)
        else $error("load_valid and fault high in the same cycle");

    idle_quiet_a: assert property (quiet_after_idle)
        else $error("load_valid or fault high after a cycle without request");

endmodule

`default_nettype wire

// File: testbench/mem_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_tb
    import mem_pkg::*;
;

    typedef struct {
        logic    valid;
        opcode_t op;
        funct3_t f3;
        addr_t   addr;
        word_t   data;
        logic    flt;
    } req_t;

    localparam opcode_t OP_ALU    = 7'b0110011;
    localparam opcode_t OP_ALUIMM = 7'b0010011;

    logic    clk;
    logic    rst_n;
    logic    req_valid;
    opcode_t opcode;
    funct3_t funct3;
    addr_t   addr;
    word_t   store_data;
    logic    load_valid;
    word_t   load_data;
    logic    fault;

    req_t       table_q [$];
    logic [7:0] ref_mem [1024];
    logic [31:0] rng;

    tb_clock i_tb_clock (.clk(clk), .rst_n(rst_n));

    mem_stage #(.DEPTH_WORDS(256)) i_mem_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .opcode     (opcode),
        .funct3     (funct3),
        .addr       (addr),
        .store_data (store_data),
        .load_valid (load_valid),
        .load_data  (load_data),
        .fault      (fault)
    );

    bind mem_stage mem_stage_checker i_mem_stage_checker (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid),
        .load_valid(load_valid), .fault(fault)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_req(input logic v, input opcode_t op, input funct3_t f3,
                           input addr_t a, input word_t d, input logic flt);
        req_t r;
        r.valid = v;
        r.op    = op;
        r.f3    = f3;
        r.addr  = a;
        r.data  = d;
        r.flt   = flt;
        table_q.push_back(r);
    endtask

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // Reference model that also updates ref_mem for stores
    task automatic predict(input req_t r, output logic lv, output logic flt,
                           output word_t d);
        logic [7:0]  b;
        logic [15:0] h;
        word_t       w;
        lv  = 1'b0;
        flt = r.flt;
        d   = '0;
        if (r.valid && !r.flt && r.op == OP_LOAD) begin
            w  = {ref_mem[{r.addr[9:2], 2'd3}], ref_mem[{r.addr[9:2], 2'd2}],
                  ref_mem[{r.addr[9:2], 2'd1}], ref_mem[{r.addr[9:2], 2'd0}]};
            b  = ref_mem[r.addr[9:0]];
            h  = {ref_mem[{r.addr[9:1], 1'b1}], ref_mem[{r.addr[9:1], 1'b0}]};
            lv = 1'b1;
            case (r.f3[1:0])
                2'd0:    d = r.f3[2] ? {24'd0, b} : {{24{b[7]}}, b};
                2'd1:    d = r.f3[2] ? {16'd0, h} : {{16{h[15]}}, h};
                default: d = w;
            endcase
        end else if (r.valid && !r.flt && r.op == OP_STORE) begin
            case (r.f3)
                3'd0: ref_mem[r.addr[9:0]] = r.data[7:0];
                3'd1: begin
                    ref_mem[{r.addr[9:1], 1'b0}] = r.data[7:0];
                    ref_mem[{r.addr[9:1], 1'b1}] = r.data[15:8];
                end
                default: begin
                    ref_mem[{r.addr[9:2], 2'd0}] = r.data[7:0];
                    ref_mem[{r.addr[9:2], 2'd1}] = r.data[15:8];
                    ref_mem[{r.addr[9:2], 2'd2}] = r.data[23:16];
                    ref_mem[{r.addr[9:2], 2'd3}] = r.data[31:24];
                end
            endcase
        end
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] r2;
        logic [1:0]  sz;
        funct3_t     f3;
        logic        is_store;
        // Fill every word so no load sees undefined data
        for (int i = 0; i < 256; i++) begin
            a = 32'(i) << 2;
            add_req(1, OP_STORE, 3'd2, a, (a * 32'h0100_0193) ^ 32'ha5c3_0f1e, 0);
        end
        // Word store and load back
        add_req(1, OP_STORE, 3'd2, 32'h100, 32'hdead_beef, 0);
        add_req(1, OP_LOAD,  3'd2, 32'h100, 32'h0, 0);
        // Byte and half merges
        add_req(1, OP_STORE, 3'd2, 32'h104, 32'h1122_3344, 0);
        add_req(1, OP_STORE, 3'd0, 32'h105, 32'h0000_00aa, 0);
        add_req(1, OP_STORE, 3'd0, 32'h107, 32'h0000_0055, 0);
        add_req(1, OP_LOAD,  3'd2, 32'h104, 32'h0, 0);
        add_req(1, OP_STORE, 3'd1, 32'h106, 32'h0000_7e80, 0);
        add_req(1, OP_STORE, 3'd0, 32'h104, 32'h0000_0099, 0);
        add_req(1, OP_STORE, 3'd0, 32'h106, 32'h0000_0012, 0);
        add_req(1, OP_LOAD,  3'd2, 32'h104, 32'h0, 0);
        add_req(1, OP_STORE, 3'd1, 32'h104, 32'h0000_c3d4, 0);
        add_req(1, OP_LOAD,  3'd2, 32'h104, 32'h0, 0);
        // Sign and zero extension
        add_req(1, OP_STORE, 3'd2, 32'h108, 32'h80ff_7f01, 0);
        add_req(1, OP_LOAD,  3'd0, 32'h108, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd0, 32'h109, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd0, 32'h10a, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd0, 32'h10b, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd4, 32'h10b, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd4, 32'h109, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd1, 32'h108, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd1, 32'h10a, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd5, 32'h10a, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd5, 32'h108, 32'h0, 0);
        // Misaligned and illegal sizes
        add_req(1, OP_LOAD,  3'd1, 32'h101, 32'h0, 1);
        add_req(1, OP_LOAD,  3'd2, 32'h102, 32'h0, 1);
        add_req(1, OP_LOAD,  3'd3, 32'h100, 32'h0, 1);
        add_req(1, OP_STORE, 3'd1, 32'h103, 32'hffff_ffff, 1);
        add_req(1, OP_STORE, 3'd2, 32'h106, 32'hffff_ffff, 1);
        for (int f = 3; f < 8; f++) begin
            add_req(1, OP_STORE, 3'(f), 32'h100, 32'h1234_5678, 1);
        end
        add_req(1, OP_LOAD,  3'd2, 32'h100, 32'h0, 0);
        add_req(1, OP_LOAD,  3'd2, 32'h104, 32'h0, 0);
        // Other opcodes and an idle slot
        add_req(1, OP_ALU,    3'd2, 32'h100, 32'h0, 0);
        add_req(1, OP_ALUIMM, 3'd1, 32'h101, 32'h0, 0);
        add_req(0, OP_LOAD,   3'd2, 32'h100, 32'h0, 0);
        add_req(1, OP_LOAD,   3'd2, 32'h108, 32'h0, 0);
        // Random aligned traffic over the whole address space
        rng = 32'hf3b3_5f49;
        for (int i = 0; i < 300; i++) begin
            rng      = lcg_next(rng);
            r2       = lcg_next(rng);
            is_store = rng[31];
            sz  = (rng[27:26] == 2'd3) ? 2'd2 : rng[27:26];
            f3  = {1'b0, sz};
            a   = r2;
            if (sz == 2'd2) a[1:0] = 2'b00;
            if (sz == 2'd1) a[0] = 1'b0;
            // Unsigned forms exist only for loads
            if (sz != 2'd2 && !is_store && rng[25]) begin
                f3[2] = 1'b1;
            end
            rng = lcg_next(r2);
            add_req(1, is_store ? OP_STORE : OP_LOAD, f3, a, lcg_next(rng), 0);
        end
    endtask

    initial begin
        req_t  r;
        logic  exp_lv;
        logic  exp_flt;
        word_t exp_d;
        int    wait_cnt;
        req_valid  = 1'b0;
        opcode     = '0;
        funct3     = '0;
        addr       = '0;
        store_data = '0;
        exp_lv     = 1'b0;
        exp_flt    = 1'b0;
        exp_d      = '0;
        build_table();
        wait_cnt = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 50) begin
                $display("Reset was never released");
                $display("TEST FAILED");
                $fatal(1);
            end
        end
        for (int i = 0; i <= table_q.size(); i++) begin
            @(posedge clk);
            if (i < table_q.size()) begin
                r = table_q[i];
                req_valid  <= r.valid;
                opcode     <= r.op;
                funct3     <= r.f3;
                addr       <= r.addr;
                store_data <= r.data;
            end else begin
                req_valid <= 1'b0;
            end
            @(negedge clk);
            // Outputs now belong to the entry accepted at this edge
            if (i > 0) begin
                compare_flag("load_valid", load_valid, exp_lv);
                compare_flag("fault", fault, exp_flt);
                if (exp_lv) begin
                    compare_word("load_data", load_data, exp_d);
                end
            end
            if (i < table_q.size()) begin
                predict(table_q[i], exp_lv, exp_flt, exp_d);
            end
        end
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
design/mem_pkg.sv
design/mem_bus_if.sv
design/mem_ctrl.sv
design/lsu_align.sv
design/data_ram.sv
design/mem_stage.sv
testbench/tb_clock.sv
testbench/mem_stage_checker.sv
testbench/mem_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module mem_stage_tb \
    -o mem_stage_sim > build.log 2>&1 \
    && ./obj_dir/mem_stage_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "TEST OK" sim.log 2>/dev/null && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
